// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS = 32;

    // addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    // one decoded instruction
    typedef struct packed {
        alu_op_t    alu_op;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        logic       use_imm;
        logic       use_pc;
        logic       writes_rd;
        logic       is_branch;
        logic [2:0] br_cond;
        logic       is_jal;
        logic       is_jalr;
    } dec_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        logic     writes;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

// ==== verilog/rv_fetch.sv ====
module rv_fetch import rv_pkg::*; #(
    parameter pc_t START_ADDR = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_n,
    input  redirect_t redirect,
    input  word_t     fetch_inst,
    output pc_t       fetch_pc,
    output logic      if_valid,
    output pc_t       if_pc,
    output word_t     if_word
);

    pc_t pc_next;

    // sequential fetch unless execute resolved a taken branch or jump
    assign pc_next = redirect.valid ? redirect.target : fetch_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= START_ADDR;
            if_valid <= 1'b0;
        end else begin
            fetch_pc <= pc_next;
            // word arriving next cycle is on the wrong path
            if_valid <= !redirect.valid;
        end
    end

    // pc of the word the memory returns this cycle
    always_ff @(posedge clk) begin
        if_pc <= fetch_pc;
    end

    // memory output acts as the IF data register
    assign if_word = if_valid ? fetch_inst : NOP_WORD;

    // targets must stay on word boundaries
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.valid |-> (redirect.target[1:0] == 2'b00)
    );

endmodule

// ==== verilog/rv_decode.sv ====
module rv_decode import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      if_valid,
    input  pc_t       if_pc,
    input  word_t     if_word,
    input  redirect_t redirect,
    output reg_idx_t  rs1_num,
    output reg_idx_t  rs2_num,
    output logic      de_valid,
    output pc_t       de_pc,
    output dec_t      de_dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       op_ok;
    logic       op_imm_ok;
    dec_t       dec;

    assign opcode  = if_word[6:0];
    assign rd      = if_word[11:7];
    assign funct3  = if_word[14:12];
    assign funct7  = if_word[31:25];

    // source numbers go straight to the regfile so its read lines up with DE
    assign rs1_num = if_word[19:15];
    assign rs2_num = if_word[24:20];

    assign imm_i = {{20{if_word[31]}}, if_word[31:20]};
    assign imm_u = {if_word[31:12], 12'h000};
    assign imm_b = {{19{if_word[31]}}, if_word[31], if_word[7], if_word[30:25],
                    if_word[11:8], 1'b0};
    assign imm_j = {{11{if_word[31]}}, if_word[31], if_word[19:12], if_word[20],
                    if_word[30:21], 1'b0};

    // funct7 only selects sub and sra
    assign op_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign op_imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                       (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                       1'b1;

    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec         = '0;
        dec.alu_op  = ALU_ADD;
        dec.rs1     = rs1_num;
        dec.rs2     = rs2_num;
        dec.rd      = rd;
        dec.br_cond = funct3;
        case (opcode)
            OPC_OP: begin
                dec.alu_op    = alu_from_funct3(funct3, funct7[5]);
                dec.writes_rd = op_ok;
            end
            OPC_OP_IMM: begin
                // addi with imm bit 10 set is still an add
                dec.alu_op    = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.writes_rd = op_imm_ok;
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                dec.imm       = imm_i;
                dec.is_jalr   = (funct3 == 3'b000);
                dec.writes_rd = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = (funct3[2:1] != 2'b01);
            end
            default: begin
                // unsupported, retires as a nop
                dec.writes_rd = 1'b0;
            end
        endcase
        // x0 is never a destination
        if (rd == '0) begin
            dec.writes_rd = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= if_valid && !redirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        de_pc  <= if_pc;
        de_dec <= dec;
    end

endmodule

// ==== verilog/rv_regfile.sv ====
module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_num,
    input  reg_idx_t rs2_num,
    input  wb_t      wb,
    output word_t    rs1_val,
    output word_t    rs2_val
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rs1_val <= '0;
            rs2_val <= '0;
        end else begin
            if (wb.valid && wb.rd != '0) begin
                regs[wb.rd] <= wb.data;
            end
            // same-cycle write is not visible here, forward covers it
            rs1_val <= regs[rs1_num];
            rs2_val <= regs[rs2_num];
        end
    end

    // x0 reads back as zero whatever retired before
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1_num == '0) |=> (rs1_val == '0)
    );

endmodule

// ==== verilog/rv_forward.sv ====
module rv_forward import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  dec_t  de_dec,
    input  word_t rs1_val,
    input  word_t rs2_val,
    input  wb_t   ex_wb,
    input  wb_t   wb,
    output word_t rs1_fwd,
    output word_t rs2_fwd
);

    // write that reached the regfile one cycle ago
    wb_t wb_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_prev <= '0;
        end else begin
            wb_prev <= wb;
        end
    end

    // youngest matching producer wins
    function automatic word_t pick(input reg_idx_t num, input word_t raw, input wb_t youngest,
                                   input wb_t middle, input wb_t oldest);
        word_t val;
        val = raw;
        if (num != '0) begin
            if (youngest.valid && youngest.rd == num) begin
                val = youngest.data;
            end else if (middle.valid && middle.rd == num) begin
                val = middle.data;
            end else if (oldest.valid && oldest.rd == num) begin
                val = oldest.data;
            end
        end
        return val;
    endfunction

    assign rs1_fwd = pick(de_dec.rs1, rs1_val, ex_wb, wb, wb_prev);
    assign rs2_fwd = pick(de_dec.rs2, rs2_val, ex_wb, wb, wb_prev);

endmodule

// ==== verilog/rv_execute.sv ====
module rv_execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      de_valid,
    input  pc_t       de_pc,
    input  dec_t      de_dec,
    input  word_t     rs1_fwd,
    input  word_t     rs2_fwd,
    output redirect_t redirect,
    output wb_t       ex_wb,
    output wb_t       wb,
    output retire_t   retire
);

    logic  ex_valid;
    pc_t   ex_pc;
    dec_t  ex_dec;
    word_t ex_rs1;
    word_t ex_rs2;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t jalr_sum;
    logic  cond_true;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            // the instruction behind a taken jump is squashed
            ex_valid <= de_valid && !redirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc  <= de_pc;
        ex_dec <= de_dec;
        ex_rs1 <= rs1_fwd;
        ex_rs2 <= rs2_fwd;
    end

    assign op_a = ex_dec.use_pc ? ex_pc : ex_rs1;
    assign op_b = ex_dec.use_imm ? ex_dec.imm : ex_rs2;

    always_comb begin
        case (ex_dec.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            default:  alu_out = op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (ex_dec.br_cond)
            3'b000:  cond_true = (ex_rs1 == ex_rs2);
            3'b001:  cond_true = (ex_rs1 != ex_rs2);
            3'b100:  cond_true = ($signed(ex_rs1) < $signed(ex_rs2));
            3'b101:  cond_true = ($signed(ex_rs1) >= $signed(ex_rs2));
            3'b110:  cond_true = (ex_rs1 < ex_rs2);
            default: cond_true = (ex_rs1 >= ex_rs2);
        endcase
    end

    assign jalr_sum = ex_rs1 + ex_dec.imm;

    assign redirect.valid  = ex_valid &&
                             (ex_dec.is_jal || ex_dec.is_jalr || (ex_dec.is_branch && cond_true));
    assign redirect.target = ex_dec.is_jalr ? {jalr_sum[31:1], 1'b0} : ex_pc + ex_dec.imm;

    // jumps write the link address
    assign ex_wb.valid = ex_valid && ex_dec.writes_rd;
    assign ex_wb.rd    = ex_dec.rd;
    assign ex_wb.data  = (ex_dec.is_jal || ex_dec.is_jalr) ? ex_pc + 32'd4 : alu_out;

    always_ff @(posedge clk) begin
        wb.rd         <= ex_wb.rd;
        wb.data       <= ex_wb.data;
        retire.pc     <= ex_pc;
        retire.writes <= ex_wb.valid;
        retire.rd     <= ex_wb.rd;
        retire.data   <= ex_wb.data;
        if (!rst_n) begin
            wb.valid     <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            wb.valid     <= ex_wb.valid;
            retire.valid <= ex_valid;
        end
    end

    // decode never lets a write to x0 through
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire.valid && retire.writes) |-> (retire.rd != '0)
    );

endmodule

// ==== verilog/rv_core.sv ====
module rv_core import rv_pkg::*; #(
    parameter pc_t START_ADDR = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    rst_n,
    output pc_t     fetch_pc,
    input  word_t   fetch_inst,
    output retire_t retire
);

    // IF stage
    logic      if_valid;
    pc_t       if_pc;
    word_t     if_word;

    // DE stage and register file read
    reg_idx_t  rs1_num;
    reg_idx_t  rs2_num;
    logic      de_valid;
    pc_t       de_pc;
    dec_t      de_dec;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     rs1_fwd;
    word_t     rs2_fwd;

    // from execute
    redirect_t redirect;
    wb_t       ex_wb;
    wb_t       wb;

    rv_fetch #(
        .START_ADDR(START_ADDR)
    ) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .fetch_inst(fetch_inst),
        .fetch_pc  (fetch_pc),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_word   (if_word)
    );

    rv_decode i_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_valid(if_valid),
        .if_pc   (if_pc),
        .if_word (if_word),
        .redirect(redirect),
        .rs1_num (rs1_num),
        .rs2_num (rs2_num),
        .de_valid(de_valid),
        .de_pc   (de_pc),
        .de_dec  (de_dec)
    );

    rv_regfile i_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1_num(rs1_num),
        .rs2_num(rs2_num),
        .wb     (wb),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val)
    );

    rv_forward i_forward (
        .clk    (clk),
        .rst_n  (rst_n),
        .de_dec (de_dec),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .ex_wb  (ex_wb),
        .wb     (wb),
        .rs1_fwd(rs1_fwd),
        .rs2_fwd(rs2_fwd)
    );

    rv_execute i_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .de_valid(de_valid),
        .de_pc   (de_pc),
        .de_dec  (de_dec),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd),
        .redirect(redirect),
        .ex_wb   (ex_wb),
        .wb      (wb),
        .retire  (retire)
    );

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== dv/tb_core.sv ====
module tb_core import rv_pkg::*; ();

    localparam pc_t START_ADDR     = 32'h0000_0100;
    localparam int  PROG_LEN       = 400;
    localparam pc_t LOOP_PC        = START_ADDR + 4 * (PROG_LEN - 1);
    localparam int  LOOP_RETIRES   = 5;
    localparam int  RESET_TIMEOUT  = 20;
    localparam int  RETIRE_TIMEOUT = 40;
    localparam int  SEED           = 71291;

    typedef word_t regfile_t [NUM_REGS];

    logic     clk;
    logic     rst_n;
    pc_t      fetch_pc;
    word_t    fetch_inst;
    retire_t  retire;

    word_t    prog [PROG_LEN];
    logic     is_target [PROG_LEN];
    pc_t      fetch_addr;
    regfile_t model_regs;
    pc_t      model_pc;
    int       loop_hits;

    tb_clock i_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    rv_core #(
        .START_ADDR(START_ADDR)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_pc  (fetch_pc),
        .fetch_inst(fetch_inst),
        .retire    (retire)
    );

    function automatic reg_idx_t any_reg();
        return reg_idx_t'($urandom_range(0, 7));
    endfunction

    // x7 is left to the jalr setup sequences
    function automatic reg_idx_t dest_reg();
        return reg_idx_t'($urandom_range(0, 6));
    endfunction

    function automatic word_t branch_word(input int slots, input logic [2:0] cond);
        logic [12:0] off;
        off = 13'(4 * slots);
        return {off[12], off[10:5], any_reg(), any_reg(), cond, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_word(input int slots, input reg_idx_t rd);
        logic [20:0] off;
        off = 21'(4 * slots);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // random program, all control flow forward except the final self-loop
    task automatic build_program();
        int         i;
        int         kind;
        int         k;
        int         off;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      base;
        word_t      upper;
        for (i = 0; i < PROG_LEN; i++) begin
            is_target[i] = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            kind = $urandom_range(0, 99);
            f3   = 3'($urandom_range(0, 7));
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            k    = $urandom_range(1, 6);
            if (i + k > PROG_LEN - 1) begin
                k = PROG_LEN - 1 - i;
            end
            if (kind < 35) begin
                prog[i] = {f7, any_reg(), any_reg(), f3, dest_reg(), OPC_OP};
            end else if (kind < 62) begin
                // shift amount in the low five bits, srai keeps funct7
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    prog[i] = {f7, 5'($urandom), any_reg(), f3, dest_reg(), OPC_OP_IMM};
                end else begin
                    prog[i] = {12'($urandom), any_reg(), f3, dest_reg(), OPC_OP_IMM};
                end
            end else if (kind < 68) begin
                prog[i] = {20'($urandom), dest_reg(), OPC_LUI};
            end else if (kind < 73) begin
                prog[i] = {20'($urandom), dest_reg(), OPC_AUIPC};
            end else if (kind < 83) begin
                f3 = 3'($urandom_range(0, 5));
                if (f3 > 3'd1) begin
                    f3 = f3 + 3'd2;
                end
                prog[i] = branch_word(k, f3);
                is_target[i + k] = 1'b1;
            end else if (kind < 88) begin
                prog[i] = jal_word(k, dest_reg());
                is_target[i + k] = 1'b1;
            end else if (kind < 94 && i + 3 <= PROG_LEN - 1 && !is_target[i + 1] &&
                         !is_target[i + 2]) begin
                // lui/addi build the target in x7, odd offsets test bit 0 clearing
                k = $urandom_range(1, 6);
                if (i + 2 + k > PROG_LEN - 1) begin
                    k = PROG_LEN - 3 - i;
                end
                off   = $urandom_range(0, 1);
                base  = START_ADDR + 4 * (i + 2 + k);
                upper = base + 32'h800;
                prog[i]     = {upper[31:12], 5'd7, OPC_LUI};
                prog[i + 1] = {base[11:0], 5'd7, 3'b000, 5'd7, OPC_OP_IMM};
                prog[i + 2] = {12'(off), 5'd7, 3'b000, dest_reg(), OPC_JALR};
                is_target[i + 2 + k] = 1'b1;
                i = i + 2;
            end else begin
                // load, store, ecall, fence
                case (kind % 4)
                    0: prog[i] = {12'($urandom), any_reg(), 3'b010, dest_reg(), 7'b0000011};
                    1: prog[i] = {7'($urandom), any_reg(), any_reg(), 3'b010, 5'($urandom),
                                  7'b0100011};
                    2: prog[i] = 32'h0000_0073;
                    default: prog[i] = 32'h0ff0_000f;
                endcase
            end
            i++;
        end
        prog[PROG_LEN - 1] = jal_word(0, 5'd0);
    endtask

    function automatic word_t read_word(input pc_t addr);
        int idx;
        idx = int'((addr - START_ADDR) >> 2);
        if (addr < START_ADDR || idx >= PROG_LEN || addr[1:0] != 2'b00) begin
            return NOP_WORD;
        end
        return prog[idx];
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                      input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    sa = sa >>> b[4:0];
                    return sa;
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model of one instruction
    function automatic retire_t ref_step(input pc_t pc, input word_t inst, input regfile_t regs,
                                         output pc_t next_pc);
        retire_t    r;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        logic       taken;
        f3       = inst[14:12];
        a        = regs[inst[19:15]];
        b        = regs[inst[24:20]];
        imm_i    = {{20{inst[31]}}, inst[31:20]};
        taken    = 1'b0;
        next_pc  = pc + 32'd4;
        r        = '0;
        r.valid  = 1'b1;
        r.pc     = pc;
        r.rd     = inst[11:7];
        r.writes = 1'b1;
        case (inst[6:0])
            OPC_OP:     r.data = alu_ref(f3, inst[30], a, b);
            OPC_OP_IMM: r.data = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);
            OPC_LUI:    r.data = {inst[31:12], 12'h000};
            OPC_AUIPC:  r.data = pc + {inst[31:12], 12'h000};
            OPC_JAL: begin
                r.data  = pc + 32'd4;
                next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                                1'b0};
            end
            OPC_JALR: begin
                r.data  = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                r.writes = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8],
                                    1'b0};
                end
            end
            default: r.writes = 1'b0;
        endcase
        // x0 never changes
        if (r.rd == 5'd0) begin
            r.writes = 1'b0;
        end
        return r;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_pc(input string what, input pc_t got, input pc_t want);
        if (got !== want) begin
            $display("** Error at %0t: %s 0x%08h, expected 0x%08h", $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic compare_write_flag(input logic got, input logic want, input pc_t pc);
        if (got !== want) begin
            $display("** Error at %0t: pc 0x%08h write flag %0b, expected %0b",
                     $time, pc, got, want);
            abort_run();
        end
    endtask

    task automatic compare_reg_write(input reg_idx_t got_rd, input word_t got_data,
                                     input reg_idx_t want_rd, input word_t want_data);
        if (got_rd !== want_rd || got_data !== want_data) begin
            $display("** Error at %0t: wrote x%0d = 0x%08h, expected x%0d = 0x%08h",
                     $time, got_rd, got_data, want_rd, want_data);
            abort_run();
        end
    endtask

    // retire outputs are sampled on the falling edge
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retire.valid !== 1'b1) begin
            cycles++;
            if (cycles > RETIRE_TIMEOUT) begin
                $display("timeout: nothing retired for %0d cycles", RETIRE_TIMEOUT);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    // instruction memory with one cycle of read latency
    initial begin
        fetch_inst = NOP_WORD;
        forever begin
            @(negedge clk);
            fetch_addr = fetch_pc;
            @(posedge clk);
            #1;
            fetch_inst = read_word(fetch_addr);
        end
    end

    initial begin
        int      cycles;
        retire_t want;
        pc_t     next_pc;
        void'($urandom(SEED));
        build_program();
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        model_pc  = START_ADDR;
        loop_hits = 0;
        cycles    = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("timeout: reset was never released");
                abort_run();
            end
        end
        // fetch starts at the reset vector
        compare_pc("fetch pc after reset", fetch_pc, START_ADDR);
        while (loop_hits < LOOP_RETIRES) begin
            wait_retire();
            want = ref_step(model_pc, read_word(model_pc), model_regs, next_pc);
            compare_pc("retired pc", retire.pc, want.pc);
            compare_write_flag(retire.writes, want.writes, want.pc);
            if (want.writes) begin
                compare_reg_write(retire.rd, retire.data, want.rd, want.data);
                model_regs[want.rd] = want.data;
            end
            // a taken jump or branch has already steered fetch to its target
            if (next_pc != want.pc + 32'd4) begin
                compare_pc("fetch pc after redirect", fetch_pc, next_pc);
            end
            if (want.pc == LOOP_PC) begin
                loop_hits++;
            end
            model_pc = next_pc;
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_forward.sv
verilog/rv_execute.sv
verilog/rv_core.sv
dv/tb_clock.sv
dv/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build the core testbench with Verilator, run it and check the log

LOG=sim.log
BUILD_DIR=obj_dir
SIM=tb_core_sim

verilator --binary --timing --assert -f files.f --top-module tb_core \
    -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
echo "no pass line found in $LOG"
exit 1
